//--- src.f
+incdir+bench
hdl/llc_pkg.sv
hdl/llc_stage_if.sv
hdl/llc_input_decoder.sv
hdl/llc_stall_regs.sv
hdl/llc_tag_stage.sv
hdl/llc_result_stage.sv
hdl/llc_front.sv
bench/llc_front_tb.sv

//--- Makefile
SIM := obj_dir/Vllc_front_tb

.PHONY: all lint clean

all: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -qF "Simulation completed successfully"

$(SIM): src.f hdl/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing -j 0 -f src.f --top-module llc_front_tb

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module llc_front

clean:
	rm -rf obj_dir

//--- bench/llc_front_tests.svh
`ifndef LLC_FRONT_TESTS_SVH
`define LLC_FRONT_TESTS_SVH

// valid holds until ready is seen, transfer on the following edge
task automatic send_fill(input line_addr_t addr);
    @(posedge clk);
    rsp_valid <= 1'b1;
    rsp_addr <= addr;
    @(negedge clk);
    while (!rsp_ready) @(negedge clk);
    @(posedge clk);
    rsp_valid <= 1'b0;
endtask

task automatic send_req(input line_addr_t addr);
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr <= addr;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b0;
endtask

task automatic send_reset();
    @(posedge clk);
    rst_valid <= 1'b1;
    @(negedge clk);
    while (!rst_ready) @(negedge clk);
    @(posedge clk);
    rst_valid <= 1'b0;
endtask

task automatic wait_results();
    while (exp_kind.size() != 0) @(posedge clk);
endtask

// a miss stalls until its fill, then the replay hits
task automatic lookup_line(input line_addr_t addr);
    llc_res_e kind;
    kind = model_lookup(addr);
    send_req(addr);
    if (kind == res_miss) begin
        model_fill(addr);
        expect_result(res_hit, addr);
        send_fill(addr);
    end
endtask

task automatic test_reset_walk();
    line_addr_t lines [4];
    int i;
    for (i = 0; i < 4; i++) begin
        lines[i] = {llc_tag_t'($urandom()), llc_set_t'(i * 3)};
        model_fill(lines[i]);
        send_fill(lines[i]);
    end
    wait_results();
    ref_valid = '0;
    send_reset();
    for (i = 0; i < 4; i++) begin
        lookup_line(lines[i]);
    end
    wait_results();
endtask

task automatic test_fill_hit();
    line_addr_t lines [4];
    line_addr_t other;
    int i;
    for (i = 0; i < 4; i++) begin
        lines[i] = {llc_tag_t'($urandom()), llc_set_t'(4 + i * 2)};
        model_fill(lines[i]);
        send_fill(lines[i]);
    end
    for (i = 0; i < 4; i++) begin
        lookup_line(lines[i]);
    end
    // same set, other tag
    other = lines[0] ^ line_addr_t'(12'h810);
    lookup_line(other);
    wait_results();
endtask

task automatic test_stall_replay();
    line_addr_t missed, other;
    int i;
    other = {llc_tag_t'($urandom()), llc_set_t'(1)};
    missed = {llc_tag_t'($urandom()), llc_set_t'(15)};
    model_fill(other);
    send_fill(other);
    void'(model_lookup(missed));
    send_req(missed);
    wait_results();
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr <= other;
    for (i = 0; i < 8; i++) begin
        @(negedge clk);
        if (req_ready) begin
            protocol_errors++;
            $display("[ERROR] %0t request accepted while a miss was stalled", $time);
        end
    end
    model_fill(missed);
    expect_result(res_hit, missed);
    void'(model_lookup(other));
    fork
        send_fill(missed);
        send_req(other);
    join
    wait_results();
endtask

task automatic test_priority();
    line_addr_t addr;
    addr = {llc_tag_t'($urandom()), llc_set_t'(12)};
    model_fill(addr);
    void'(model_lookup(addr));
    fork
        send_fill(addr);
        send_req(addr);
    join
    wait_results();
endtask

task automatic test_credit_backpressure();
    line_addr_t lines [4];
    int start, i, j;
    for (i = 0; i < 4; i++) begin
        lines[i] = {llc_tag_t'($urandom()), llc_set_t'(i)};
        model_fill(lines[i]);
    end
    // earlier credits are all back by this edge
    @(negedge clk);
    auto_credit = 1'b0;
    @(posedge clk);
    start = sent_count;
    fork
        begin
            for (i = 0; i < 4; i++) begin
                send_fill(lines[i]);
            end
        end
        begin
            while (sent_count - start < llc_credits) @(posedge clk);
            for (j = 0; j < 10; j++) begin
                @(negedge clk);
                if (result_valid) begin
                    protocol_errors++;
                    $display("[ERROR] %0t result sent with no credit left", $time);
                end
            end
            @(posedge clk);
            if (sent_count - start != llc_credits) begin
                protocol_errors++;
                $display("[ERROR] %0t %0d results sent on %0d credits", $time,
                         sent_count - start, llc_credits);
            end
            @(negedge clk);
            auto_credit = 1'b1;
        end
    join
    wait_results();
endtask

`endif

//--- bench/llc_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module llc_front_tb;
    import llc_pkg::*;

    // all tests together take a few hundred cycles
    localparam int timeout_cycles = 4000;
    localparam int rand_seed = 32'h938;

    logic clk;
    logic rst;
    logic rst_valid, rst_ready;
    logic rsp_valid, rsp_ready;
    logic req_valid, req_ready;
    line_addr_t rsp_addr, req_addr;
    logic result_valid;
    llc_res_e result_kind;
    llc_tag_t result_tag;
    llc_set_t result_set;
    logic credit_return = 1'b0;

    // reference tag array and the expected results in issue order
    llc_tag_t ref_tag [llc_sets];
    bit [llc_sets-1:0] ref_valid;
    llc_res_e exp_kind [$];
    line_addr_t exp_addr [$];
    line_addr_t exp_line;

    int checked, mismatches, protocol_errors;
    int sent_count, returned_count, cycles;
    bit auto_credit = 1'b1;

    llc_front llc_front_i (
        .clk(clk), .rst(rst),
        .rst_valid(rst_valid), .rst_ready(rst_ready),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_addr(rsp_addr),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .result_valid(result_valid), .result_kind(result_kind),
        .result_tag(result_tag), .result_set(result_set),
        .credit_return(credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic void expect_result(input llc_res_e kind, input line_addr_t addr);
        exp_kind.push_back(kind);
        exp_addr.push_back(addr);
    endfunction

    function automatic void model_fill(input line_addr_t addr);
        ref_tag[addr[llc_set_bits-1:0]] = addr[llc_addr_bits-1 -: llc_tag_bits];
        ref_valid[addr[llc_set_bits-1:0]] = 1'b1;
        expect_result(res_fill, addr);
    endfunction

    function automatic llc_res_e model_lookup(input line_addr_t addr);
        llc_set_t set;
        llc_res_e kind;
        set = addr[llc_set_bits-1:0];
        if (ref_valid[set] && ref_tag[set] == addr[llc_addr_bits-1 -: llc_tag_bits]) begin
            kind = res_hit;
        end else begin
            kind = res_miss;
        end
        expect_result(kind, addr);
        return kind;
    endfunction

    task automatic check_kind(input llc_res_e expected, input llc_res_e actual);
        checked++;
        if (actual !== expected) begin
            mismatches++;
            $display("[ERROR] %0t result kind %s, expected %s", $time,
                     actual.name(), expected.name());
        end
    endtask

    task automatic check_line(input llc_tag_t exp_tag, input llc_tag_t act_tag,
                              input llc_set_t exp_set, input llc_set_t act_set);
        checked++;
        if (act_tag !== exp_tag || act_set !== exp_set) begin
            mismatches++;
            $display("[ERROR] %0t result line tag %h set %h, expected tag %h set %h",
                     $time, act_tag, act_set, exp_tag, exp_set);
        end
    endtask

    // a result leaves on the posedge after a negedge with result_valid high
    always @(negedge clk) begin
        if (rst && result_valid) begin
            sent_count++;
            if (exp_kind.size() == 0) begin
                mismatches++;
                $display("[ERROR] %0t unexpected result %s for set %0d", $time,
                         result_kind.name(), result_set);
            end else begin
                exp_line = exp_addr.pop_front();
                check_kind(exp_kind.pop_front(), result_kind);
                check_line(exp_line[llc_addr_bits-1 -: llc_tag_bits], result_tag,
                           exp_line[llc_set_bits-1:0], result_set);
            end
        end
    end

    // one credit back per result a cycle later
    always @(posedge clk) begin
        if (auto_credit && sent_count > returned_count) begin
            credit_return <= 1'b1;
            returned_count++;
        end else begin
            credit_return <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    `include "llc_front_tests.svh"

    initial begin
        void'($urandom(rand_seed));
        rst <= 1'b0;
        rst_valid <= 1'b0;
        rsp_valid <= 1'b0;
        rsp_addr <= '0;
        req_valid <= 1'b0;
        req_addr <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        test_reset_walk();
        test_fill_hit();
        test_stall_replay();
        test_priority();
        test_credit_backpressure();
        repeat (2) @(posedge clk);
        $display("results checked: %0d, mismatches: %0d, protocol errors: %0d",
                 checked, mismatches, protocol_errors);
        if (mismatches == 0 && protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/llc_front.sv
`timescale 1ns/1ps
`default_nettype none

module llc_front (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                rst_valid,
    output logic                     rst_ready,
    input  wire logic                rsp_valid,
    output logic                     rsp_ready,
    input  wire llc_pkg::line_addr_t rsp_addr,
    input  wire logic                req_valid,
    output logic                     req_ready,
    input  wire llc_pkg::line_addr_t req_addr,
    output logic                     result_valid,
    output llc_pkg::llc_res_e        result_kind,
    output llc_pkg::llc_tag_t        result_tag,
    output llc_pkg::llc_set_t        result_set,
    input  wire logic                credit_return
);
    import llc_pkg::*;

    logic slot_free, issue;
    logic walk_active, start_walk, step_walk;
    logic req_stall, stalled_valid, replay;
    llc_set_t walk_set, stalled_set;
    llc_tag_t stalled_tag;

    llc_stage_if lookup_link ();
    llc_stage_if result_link ();

    llc_input_decoder llc_input_decoder_i (
        .clk(clk), .rst(rst),
        .rst_valid(rst_valid), .rsp_valid(rsp_valid), .req_valid(req_valid),
        .rsp_addr(rsp_addr), .req_addr(req_addr), .slot_free(slot_free),
        .walk_active(walk_active), .walk_set(walk_set), .req_stall(req_stall),
        .stalled_valid(stalled_valid), .stalled_tag(stalled_tag), .stalled_set(stalled_set),
        .rst_ready(rst_ready), .rsp_ready(rsp_ready), .req_ready(req_ready),
        .start_walk(start_walk), .step_walk(step_walk), .replay(replay), .issue(issue),
        .lookup(lookup_link.src)
    );

    llc_stall_regs llc_stall_regs_i (
        .clk(clk), .rst(rst),
        .start_walk(start_walk), .step_walk(step_walk), .replay(replay),
        .miss_in(result_link.dst),
        .walk_active(walk_active), .walk_set(walk_set), .req_stall(req_stall),
        .stalled_valid(stalled_valid), .stalled_tag(stalled_tag), .stalled_set(stalled_set)
    );

    llc_tag_stage llc_tag_stage_i (
        .clk(clk), .rst(rst),
        .lookup(lookup_link.dst), .result(result_link.src)
    );

    llc_result_stage llc_result_stage_i (
        .clk(clk), .rst(rst),
        .issue(issue), .credit_return(credit_return), .result(result_link.dst),
        .slot_free(slot_free), .result_valid(result_valid), .result_kind(result_kind),
        .result_tag(result_tag), .result_set(result_set)
    );

endmodule

`default_nettype wire

//--- hdl/llc_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module llc_result_stage (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         issue,
    input  wire logic         credit_return,
    llc_stage_if.dst          result,
    output logic              slot_free,
    output logic              result_valid,
    output llc_pkg::llc_res_e result_kind,
    output llc_pkg::llc_tag_t result_tag,
    output llc_pkg::llc_set_t result_set
);
    import llc_pkg::*;

    llc_res_e kind_q [llc_result_depth];
    llc_tag_t tag_q [llc_result_depth];
    llc_set_t set_q [llc_result_depth];
    logic [llc_result_ptr_bits-1:0] wr_ptr, rd_ptr;
    logic [llc_result_ptr_bits:0] count, pending;
    logic [llc_credit_bits-1:0] credits;
    logic [2:0] used;
    logic send;

    assign send = count != '0 && credits != '0;
    assign used = 3'(pending) + 3'(count);
    // reservations and held results against queue room and credits
    assign slot_free = used < 3'(llc_result_depth) && used < 3'(credits);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            pending <= '0;
            credits <= llc_credit_bits'(llc_credits);
        end else begin
            if (result.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (llc_result_ptr_bits+1)'(result.valid) -
                     (llc_result_ptr_bits+1)'(send);
            pending <= pending + (llc_result_ptr_bits+1)'(issue) -
                       (llc_result_ptr_bits+1)'(result.valid);
            credits <= credits + llc_credit_bits'(credit_return) - llc_credit_bits'(send);
        end
    end

    always_ff @(posedge clk) begin
        if (result.valid) begin
            kind_q[wr_ptr] <= llc_res_e'(result.op);
            tag_q[wr_ptr] <= result.tag;
            set_q[wr_ptr] <= result.set;
        end
    end

    assign result_valid = send;
    assign result_kind = kind_q[rd_ptr];
    assign result_tag = tag_q[rd_ptr];
    assign result_set = set_q[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/llc_tag_stage.sv
`timescale 1ns/1ps
`default_nettype none

module llc_tag_stage (
    input  wire logic clk,
    input  wire logic rst,
    llc_stage_if.dst  lookup,
    llc_stage_if.src  result
);
    import llc_pkg::*;

    llc_tag_t tags [llc_sets];
    logic [llc_sets-1:0] valid_bits;
    logic hit;
    llc_res_e kind;

    assign hit = valid_bits[lookup.set] && tags[lookup.set] == lookup.tag;

    always_comb begin
        case (llc_op_e'(lookup.op))
            op_fill:   kind = res_fill;
            op_lookup: kind = hit ? res_hit : res_miss;
            default:   kind = res_miss;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_bits <= '0;
        end else if (lookup.valid) begin
            if (lookup.op == op_fill) begin
                valid_bits[lookup.set] <= 1'b1;
            end else if (lookup.op == op_inval) begin
                valid_bits[lookup.set] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.valid && lookup.op == op_fill) begin
            tags[lookup.set] <= lookup.tag;
        end
    end

    // invalidations leave no result
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= lookup.valid && lookup.op != op_inval;
        end
    end

    always_ff @(posedge clk) begin
        result.op <= kind;
        result.tag <= lookup.tag;
        result.set <= lookup.set;
    end

endmodule

`default_nettype wire

//--- hdl/llc_stall_regs.sv
`timescale 1ns/1ps
`default_nettype none

module llc_stall_regs (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         start_walk,
    input  wire logic         step_walk,
    input  wire logic         replay,
    llc_stage_if.dst          miss_in,
    output logic              walk_active,
    output llc_pkg::llc_set_t walk_set,
    output logic              req_stall,
    output logic              stalled_valid,
    output llc_pkg::llc_tag_t stalled_tag,
    output llc_pkg::llc_set_t stalled_set
);
    import llc_pkg::*;

    logic is_miss;
    logic fill_match;

    assign is_miss = miss_in.valid && miss_in.op == res_miss;
    assign fill_match = miss_in.valid && miss_in.op == res_fill && req_stall &&
                        miss_in.tag == stalled_tag && miss_in.set == stalled_set;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            walk_active <= 1'b0;
            walk_set <= '0;
            req_stall <= 1'b0;
            stalled_valid <= 1'b0;
        end else begin
            if (start_walk) begin
                walk_active <= 1'b1;
                walk_set <= '0;
            end else if (step_walk) begin
                walk_set <= walk_set + 1'b1;
                // last set done
                if (walk_set == llc_set_t'(llc_sets - 1)) begin
                    walk_active <= 1'b0;
                end
            end
            if (is_miss) begin
                req_stall <= 1'b1;
            end else if (fill_match) begin
                req_stall <= 1'b0;
                stalled_valid <= 1'b1;
            end
            if (replay) begin
                stalled_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_miss) begin
            stalled_tag <= miss_in.tag;
            stalled_set <= miss_in.set;
        end
    end

endmodule

`default_nettype wire

//--- hdl/llc_input_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module llc_input_decoder (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               rst_valid,
    input  wire logic               rsp_valid,
    input  wire logic               req_valid,
    input  wire llc_pkg::line_addr_t rsp_addr,
    input  wire llc_pkg::line_addr_t req_addr,
    input  wire logic               slot_free,
    input  wire logic               walk_active,
    input  wire llc_pkg::llc_set_t  walk_set,
    input  wire logic               req_stall,
    input  wire logic               stalled_valid,
    input  wire llc_pkg::llc_tag_t  stalled_tag,
    input  wire llc_pkg::llc_set_t  stalled_set,
    output logic                    rst_ready,
    output logic                    rsp_ready,
    output logic                    req_ready,
    output logic                    start_walk,
    output logic                    step_walk,
    output logic                    replay,
    output logic                    issue,
    llc_stage_if.src                lookup
);
    import llc_pkg::*;

    logic any_ready;
    logic look_busy;
    logic lookup_tail;
    logic grant_rst, grant_rsp, grant_req, replay_go;
    logic rsp_xfer, req_xfer;
    line_addr_t sel_addr;

    assign any_ready = rst_ready | rsp_ready | req_ready;
    assign rsp_xfer = rsp_valid & rsp_ready;
    assign req_xfer = req_valid & req_ready;

    // lookup in the tag stage or on the result link
    assign look_busy = (lookup.valid && lookup.op == op_lookup) | lookup_tail;

    // one grant at a time, nothing while a ready is out
    always_comb begin
        grant_rst = 1'b0;
        grant_rsp = 1'b0;
        grant_req = 1'b0;
        replay_go = 1'b0;
        if (walk_active || any_ready) begin
            grant_rst = 1'b0;
        end else if (rst_valid && !req_stall) begin
            grant_rst = 1'b1;
        end else if (rsp_valid && slot_free) begin
            grant_rsp = 1'b1;
        end else if (stalled_valid && !req_stall && slot_free && !look_busy) begin
            replay_go = 1'b1;
        end else if (req_valid && !req_stall && !stalled_valid && slot_free && !look_busy) begin
            grant_req = 1'b1;
        end
    end

    assign issue = grant_rsp | grant_req | replay_go;
    assign replay = replay_go;
    assign start_walk = rst_valid & rst_ready;
    assign step_walk = walk_active;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_ready <= 1'b0;
            rsp_ready <= 1'b0;
            req_ready <= 1'b0;
            lookup.valid <= 1'b0;
            lookup_tail <= 1'b0;
        end else begin
            rst_ready <= grant_rst;
            rsp_ready <= grant_rsp;
            req_ready <= grant_req;
            lookup.valid <= walk_active | rsp_xfer | req_xfer | replay_go;
            lookup_tail <= lookup.valid && lookup.op == op_lookup;
        end
    end

    assign sel_addr = req_xfer ? req_addr : rsp_addr;

    always_ff @(posedge clk) begin
        if (walk_active) begin
            lookup.op <= op_inval;
            lookup.tag <= '0;
            lookup.set <= walk_set;
        end else if (replay_go) begin
            lookup.op <= op_lookup;
            lookup.tag <= stalled_tag;
            lookup.set <= stalled_set;
        end else begin
            lookup.op <= rsp_xfer ? op_fill : op_lookup;
            lookup.tag <= sel_addr[llc_addr_bits-1 -: llc_tag_bits];
            lookup.set <= sel_addr[llc_set_bits-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/llc_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface llc_stage_if;
    import llc_pkg::*;

    logic valid;
    // llc_op_e on the lookup link, llc_res_e on the result link
    logic [llc_op_bits-1:0] op;
    llc_tag_t tag;
    llc_set_t set;

    modport src (
        output valid, op, tag, set
    );

    modport dst (
        input valid, op, tag, set
    );

endinterface

`default_nettype wire

//--- hdl/llc_pkg.sv
`default_nettype none

package llc_pkg;

    localparam int llc_set_bits = 4;
    localparam int llc_sets = 1 << llc_set_bits;
    localparam int llc_tag_bits = 8;
    localparam int llc_addr_bits = llc_tag_bits + llc_set_bits;
    localparam int llc_op_bits = 2;

    // result slots granted downstream after reset
    localparam int llc_credits = 2;
    localparam int llc_credit_bits = 2;
    localparam int llc_result_depth = 2;
    localparam int llc_result_ptr_bits = $clog2(llc_result_depth);

    // tag in the upper bits, set in the lower bits
    typedef logic [llc_addr_bits-1:0] line_addr_t;
    typedef logic [llc_set_bits-1:0] llc_set_t;
    typedef logic [llc_tag_bits-1:0] llc_tag_t;

    typedef enum logic [llc_op_bits-1:0] {
        op_lookup = 2'd0,
        op_fill   = 2'd1,
        op_inval  = 2'd2
    } llc_op_e;

    typedef enum logic [llc_op_bits-1:0] {
        res_hit  = 2'd0,
        res_miss = 2'd1,
        res_fill = 2'd2
    } llc_res_e;

endpackage

`default_nettype wire
